// ==== Makefile ====
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module eth_tx_tb --Mdir $(OBJ)

run: compile
	@out="$$(./$(OBJ)/Veth_tx_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(OBJ)

// ==== hdl/eth_tx_pkg.sv ====
// shared types for the ethernet transmit path
// word, byte mask, slot address, packet size and packet count

`include "eth_tx_params.svh"

package eth_tx_pkg;

  // one bus word
  typedef logic [`ETH_DATA_WIDTH-1:0] word_t;

  typedef logic [`ETH_DATA_WIDTH/8-1:0] mask_t;  // byte enables

  // byte address inside one slot
  typedef logic [$clog2(`ETH_MTU)-1:0] addr_t;

  // 0 .. MTU bytes, needs one bit more than addr_t
  typedef logic [$clog2(`ETH_MTU+1)-1:0] size_t;

  typedef logic [`ETH_COUNT_WIDTH-1:0] count_t;

endpackage

// ==== hdl/eth_tx_top.sv ====
// transmit top level, two host write ports to one AXI-Stream output
// arbiter, two-slot packet buffer and sender

`timescale 1ns/1ps

module eth_tx_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               host0_claim_i,
  output logic               host0_grant_o,
  input  logic               host0_wsize_valid_i,
  input  eth_tx_pkg::size_t  host0_wsize_i,
  input  logic               host0_wvalid_i,
  input  eth_tx_pkg::addr_t  host0_waddr_i,
  input  eth_tx_pkg::word_t  host0_wdata_i,
  input  eth_tx_pkg::mask_t  host0_wmask_i,
  input  logic               host0_send_i,
  input  logic               host1_claim_i,
  output logic               host1_grant_o,
  input  logic               host1_wsize_valid_i,
  input  eth_tx_pkg::size_t  host1_wsize_i,
  input  logic               host1_wvalid_i,
  input  eth_tx_pkg::addr_t  host1_waddr_i,
  input  eth_tx_pkg::word_t  host1_wdata_i,
  input  eth_tx_pkg::mask_t  host1_wmask_i,
  input  logic               host1_send_i,
  output eth_tx_pkg::word_t  tx_axis_tdata_o,
  output eth_tx_pkg::mask_t  tx_axis_tkeep_o,
  output logic               tx_axis_tvalid_o,
  output logic               tx_axis_tlast_o,
  output logic               tx_axis_tuser_o,
  input  logic               tx_axis_tready_i,
  output eth_tx_pkg::count_t send_count_o
);
  import eth_tx_pkg::*;

  pkt_write_if wr_if ();
  pkt_read_if  rd_if ();

  host_write_arbiter arbiter_i (
    .clk_i, .reset_i,
    .host0_claim_i, .host1_claim_i,
    .host0_grant_o, .host1_grant_o,
    .host0_wsize_valid_i, .host0_wsize_i, .host0_wvalid_i,
    .host0_waddr_i, .host0_wdata_i, .host0_wmask_i, .host0_send_i,
    .host1_wsize_valid_i, .host1_wsize_i, .host1_wvalid_i,
    .host1_waddr_i, .host1_wdata_i, .host1_wmask_i, .host1_send_i,
    .wr_o (wr_if.host)
  );

  packet_buffer buffer_i (
    .clk_i, .reset_i,
    .wr_i (wr_if.buffer),
    .rd_i (rd_if.buffer)
  );

  ethernet_sender sender_i (
    .clk_i, .reset_i,
    .rd_o (rd_if.sender),
    .tx_axis_tdata_o, .tx_axis_tkeep_o, .tx_axis_tvalid_o,
    .tx_axis_tlast_o, .tx_axis_tuser_o, .tx_axis_tready_i,
    .send_count_o
  );

endmodule

// ==== hdl/ethernet_sender.sv ====
// streams committed packets from the buffer as AXI-Stream beats
// keep mask on the last beat, tlast, tuser and a saturating sent count

`timescale 1ns/1ps

`include "eth_tx_params.svh"

module ethernet_sender (
  input  logic               clk_i,
  input  logic               reset_i,
  pkt_read_if.sender         rd_o,
  output eth_tx_pkg::word_t  tx_axis_tdata_o,
  output eth_tx_pkg::mask_t  tx_axis_tkeep_o,
  output logic               tx_axis_tvalid_o,
  output logic               tx_axis_tlast_o,
  output logic               tx_axis_tuser_o,
  input  logic               tx_axis_tready_i,
  output eth_tx_pkg::count_t send_count_o
);
  import eth_tx_pkg::*;

  localparam int bytes_lp = `ETH_DATA_WIDTH / 8;
  localparam int off_w_lp = $clog2(bytes_lp);
  localparam int ptr_w_lp = $clog2(`ETH_MTU / bytes_lp);

  if (`ETH_DATA_WIDTH != 32) begin : g_width_check
    $error("ethernet_sender supports a 32-bit data path only");
  end

  logic [ptr_w_lp-1:0] beat_ptr_r;
  logic [ptr_w_lp-1:0] end_ptr;
  logic [off_w_lp-1:0] remain;
  logic                last_beat;
  logic                stall;
  logic                issue;
  mask_t               keep_next;

  mask_t  tkeep_r;
  logic   tvalid_r;
  logic   tlast_r;
  count_t send_count_r;

  // word index of the last byte
  assign end_ptr   = ptr_w_lp'((rd_o.rsize - 1'b1) >> off_w_lp);
  assign remain    = rd_o.rsize[off_w_lp-1:0];
  assign last_beat = (beat_ptr_r == end_ptr);

  assign stall = tx_axis_tvalid_o & ~tx_axis_tready_i;
  assign issue = rd_o.avail & ~stall;

  assign rd_o.rvalid = issue;
  assign rd_o.raddr  = addr_t'({beat_ptr_r, {off_w_lp{1'b0}}});
  assign rd_o.ack    = issue & last_beat;

  always_comb begin
    keep_next = '1;
    if (last_beat) begin
      case (remain)
        2'd1:    keep_next = 4'b0001;
        2'd2:    keep_next = 4'b0011;
        2'd3:    keep_next = 4'b0111;
        default: keep_next = 4'b1111;   // full last word
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      beat_ptr_r   <= '0;
      tvalid_r     <= 1'b0;
      tkeep_r      <= '0;
      tlast_r      <= 1'b0;
      send_count_r <= '0;
    end else begin
      if (issue) begin
        tvalid_r <= 1'b1;
        tkeep_r  <= keep_next;
        tlast_r  <= last_beat;
        if (last_beat) begin
          beat_ptr_r <= '0;
          if (send_count_r != '1) begin
            send_count_r <= send_count_r + 1'b1;   // saturates
          end
        end else begin
          beat_ptr_r <= beat_ptr_r + 1'b1;
        end
      end else if (tx_axis_tready_i) begin
        tvalid_r <= 1'b0;
      end
    end
  end

  // data comes straight from the buffer read register
  assign tx_axis_tdata_o  = rd_o.rdata;
  assign tx_axis_tkeep_o  = tkeep_r;
  assign tx_axis_tvalid_o = tvalid_r;
  assign tx_axis_tlast_o  = tlast_r;
  assign tx_axis_tuser_o  = 1'b0;   // no error marking
  assign send_count_o     = send_count_r;

  a_stall_holds_data: assert property (@(posedge clk_i) disable iff (!reset_i)
    tx_axis_tvalid_o && !tx_axis_tready_i |=> $stable(tx_axis_tdata_o));

  a_nonzero_size: assert property (@(posedge clk_i) disable iff (!reset_i)
    rd_o.avail |-> rd_o.rsize != '0);

endmodule

// ==== hdl/host_write_arbiter.sv ====
// round-robin arbiter for two hosts sharing the buffer write side
// ownership is held for a whole packet and released after send

`timescale 1ns/1ps

module host_write_arbiter (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               host0_claim_i,
  input  logic               host1_claim_i,
  output logic               host0_grant_o,
  output logic               host1_grant_o,
  input  logic               host0_wsize_valid_i,
  input  eth_tx_pkg::size_t  host0_wsize_i,
  input  logic               host0_wvalid_i,
  input  eth_tx_pkg::addr_t  host0_waddr_i,
  input  eth_tx_pkg::word_t  host0_wdata_i,
  input  eth_tx_pkg::mask_t  host0_wmask_i,
  input  logic               host0_send_i,
  input  logic               host1_wsize_valid_i,
  input  eth_tx_pkg::size_t  host1_wsize_i,
  input  logic               host1_wvalid_i,
  input  eth_tx_pkg::addr_t  host1_waddr_i,
  input  eth_tx_pkg::word_t  host1_wdata_i,
  input  eth_tx_pkg::mask_t  host1_wmask_i,
  input  logic               host1_send_i,
  pkt_write_if.host          wr_o
);
  import eth_tx_pkg::*;

  logic busy_r;
  logic owner_r;   // 1 = host 1
  logic last_r;    // previous winner
  logic winner;
  logic owner_send;

  assign host0_grant_o = busy_r & ~owner_r;
  assign host1_grant_o = busy_r & owner_r;

  // on a tie the host not granted last time wins
  always_comb begin
    if (host0_claim_i && host1_claim_i) begin
      winner = ~last_r;
    end else begin
      winner = host1_claim_i;
    end
  end

  assign owner_send = owner_r ? host1_send_i : host0_send_i;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      busy_r  <= 1'b0;
      owner_r <= 1'b0;
      last_r  <= 1'b1;   // host 0 wins first
    end else if (busy_r) begin
      if (owner_send) begin
        busy_r <= 1'b0;
      end
    end else if (wr_o.req && (host0_claim_i || host1_claim_i)) begin
      busy_r  <= 1'b1;
      owner_r <= winner;
      last_r  <= winner;
    end
  end

  always_comb begin
    wr_o.wsize_valid = 1'b0;
    wr_o.wsize       = '0;
    wr_o.wvalid      = 1'b0;
    wr_o.waddr       = '0;
    wr_o.wdata       = '0;
    wr_o.wmask       = '0;
    wr_o.send        = 1'b0;
    if (host0_grant_o) begin
      wr_o.wsize_valid = host0_wsize_valid_i;
      wr_o.wsize       = host0_wsize_i;
      wr_o.wvalid      = host0_wvalid_i;
      wr_o.waddr       = host0_waddr_i;
      wr_o.wdata       = host0_wdata_i;
      wr_o.wmask       = host0_wmask_i;
      wr_o.send        = host0_send_i;
    end else if (host1_grant_o) begin
      wr_o.wsize_valid = host1_wsize_valid_i;
      wr_o.wsize       = host1_wsize_i;
      wr_o.wvalid      = host1_wvalid_i;
      wr_o.waddr       = host1_waddr_i;
      wr_o.wdata       = host1_wdata_i;
      wr_o.wmask       = host1_wmask_i;
      wr_o.send        = host1_send_i;
    end
  end

  // a host lets go of its claim by the send cycle
  a_claim_released: assert property (@(posedge clk_i) disable iff (!reset_i)
    !((host0_send_i && host0_claim_i) || (host1_send_i && host1_claim_i)));

  // hosts only strobe inside their own grant window
  a_host0_strobe: assert property (@(posedge clk_i) disable iff (!reset_i)
    !host0_grant_o |-> !(host0_wsize_valid_i || host0_wvalid_i || host0_send_i));
  a_host1_strobe: assert property (@(posedge clk_i) disable iff (!reset_i)
    !host1_grant_o |-> !(host1_wsize_valid_i || host1_wvalid_i || host1_send_i));

endmodule

// ==== hdl/packet_buffer.sv ====
// ping-pong packet memory with one stored size per slot
// byte-masked word writes, synchronous word reads from the head slot

`timescale 1ns/1ps

`include "eth_tx_params.svh"

module packet_buffer (
  input  logic        clk_i,
  input  logic        reset_i,
  pkt_write_if.buffer wr_i,
  pkt_read_if.buffer  rd_i
);
  import eth_tx_pkg::*;

  localparam int bytes_lp  = `ETH_DATA_WIDTH / 8;
  localparam int words_lp  = `ETH_MTU / bytes_lp;      // words per slot
  localparam int off_w_lp  = $clog2(bytes_lp);
  localparam int word_w_lp = $clog2(words_lp);
  localparam int slot_w_lp = (`ETH_SLOTS > 1) ? $clog2(`ETH_SLOTS) : 1;
  localparam int cnt_w_lp  = $clog2(`ETH_SLOTS + 1);

  word_t mem [`ETH_SLOTS * words_lp];
  size_t sizes [`ETH_SLOTS];

  logic [slot_w_lp-1:0] wr_slot_r;
  logic [slot_w_lp-1:0] rd_slot_r;
  logic [cnt_w_lp-1:0]  full_cnt_r;   // committed, not yet acked

  logic [slot_w_lp+word_w_lp-1:0] wr_idx;
  logic [slot_w_lp+word_w_lp-1:0] rd_idx;
  word_t                          rdata_r;

  // byte address down to word index
  assign wr_idx = {wr_slot_r, wr_i.waddr[off_w_lp +: word_w_lp]};
  assign rd_idx = {rd_slot_r, rd_i.raddr[off_w_lp +: word_w_lp]};

  assign wr_i.req   = (full_cnt_r < cnt_w_lp'(`ETH_SLOTS));
  assign rd_i.avail = (full_cnt_r != '0);
  assign rd_i.rsize = sizes[rd_slot_r];
  assign rd_i.rdata = rdata_r;

  always_ff @(posedge clk_i) begin
    if (wr_i.wvalid) begin
      for (int b = 0; b < bytes_lp; b++) begin
        if (wr_i.wmask[b]) begin
          mem[wr_idx][8*b +: 8] <= wr_i.wdata[8*b +: 8];
        end
      end
    end
    if (wr_i.wsize_valid) begin
      sizes[wr_slot_r] <= wr_i.wsize;
    end
    if (rd_i.rvalid) begin
      rdata_r <= mem[rd_idx];   // held until next read
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      wr_slot_r  <= '0;
      rd_slot_r  <= '0;
      full_cnt_r <= '0;
    end else begin
      if (wr_i.send) begin
        if (wr_slot_r == slot_w_lp'(`ETH_SLOTS - 1)) begin
          wr_slot_r <= '0;
        end else begin
          wr_slot_r <= wr_slot_r + 1'b1;
        end
      end
      if (rd_i.ack) begin
        if (rd_slot_r == slot_w_lp'(`ETH_SLOTS - 1)) begin
          rd_slot_r <= '0;
        end else begin
          rd_slot_r <= rd_slot_r + 1'b1;
        end
      end
      // commit and free may land in one cycle
      if (wr_i.send && !rd_i.ack) begin
        full_cnt_r <= full_cnt_r + 1'b1;
      end else if (rd_i.ack && !wr_i.send) begin
        full_cnt_r <= full_cnt_r - 1'b1;
      end
    end
  end

  a_write_needs_req: assert property (@(posedge clk_i) disable iff (!reset_i)
    !wr_i.req |-> !(wr_i.wvalid || wr_i.wsize_valid || wr_i.send));

  a_ack_needs_avail: assert property (@(posedge clk_i) disable iff (!reset_i)
    rd_i.ack |-> rd_i.avail);

endmodule

// ==== hdl/pkt_read_if.sv ====
// read side of the packet buffer
// sender modport reads words and acks, buffer modport serves them

`timescale 1ns/1ps

interface pkt_read_if;
  import eth_tx_pkg::*;

  logic  avail;   // committed packet at head
  size_t rsize;
  word_t rdata;   // one cycle after rvalid
  logic  rvalid;
  addr_t raddr;
  logic  ack;     // frees head slot

  modport sender (
    input  avail, rsize, rdata,
    output rvalid, raddr, ack
  );

  modport buffer (
    output avail, rsize, rdata,
    input  rvalid, raddr, ack
  );

endinterface

// ==== hdl/pkt_write_if.sv ====
// write side of the packet buffer
// host modport drives writes, buffer modport answers with req

`timescale 1ns/1ps

interface pkt_write_if;
  import eth_tx_pkg::*;

  logic  wsize_valid;
  size_t wsize;
  logic  wvalid;
  addr_t waddr;
  word_t wdata;
  mask_t wmask;
  logic  send;   // commit pulse
  logic  req;    // level, a slot is free

  modport host (
    output wsize_valid, wsize, wvalid, waddr, wdata, wmask, send,
    input  req
  );

  modport buffer (
    input  wsize_valid, wsize, wvalid, waddr, wdata, wmask, send,
    output req
  );

endinterface

// ==== include/eth_tx_params.svh ====
// compile-time sizes for the ethernet transmit path
// data width, slot capacity, slot count, sent-packet counter width

`ifndef ETH_TX_PARAMS_SVH
`define ETH_TX_PARAMS_SVH

// bits per data word, only 32 is supported
`define ETH_DATA_WIDTH 32

// bytes per buffer slot
`define ETH_MTU 2048

// ping-pong buffer slots
`define ETH_SLOTS 2

// saturating sent-packet counter
`define ETH_COUNT_WIDTH 16

`endif

// ==== project.f ====
+incdir+include
hdl/eth_tx_pkg.sv
hdl/pkt_write_if.sv
hdl/pkt_read_if.sv
hdl/host_write_arbiter.sv
hdl/packet_buffer.sv
hdl/ethernet_sender.sv
hdl/eth_tx_top.sv
tests/eth_tx_tb.sv

// ==== tests/eth_tx_tb.sv ====
// testbench for the ethernet transmit top level
// clock and reset, LFSR stimulus, host driver tasks, reference beats,
// stream monitor with one compare task, and a watchdog

`timescale 1ns/1ps

module eth_tx_tb;
  import eth_tx_pkg::*;

  typedef struct packed {
    word_t data;
    mask_t keep;
    logic  last;
  } beat_t;

  // upper bounds on beats per test
  // random sizes stay at or below 64 bytes
  localparam int alt_beats_lp     = 21;
  localparam int single_beats_lp  = 8;
  localparam int remain_beats_lp  = 7;
  localparam int random_beats_lp  = 6 * 16;
  localparam int stall_beats_lp   = 10;
  localparam int max_beats_lp     = alt_beats_lp + single_beats_lp + remain_beats_lp
                                    + random_beats_lp + stall_beats_lp;
  localparam int timeout_cycles_lp = max_beats_lp * 8 + 16 + 300;

  logic   clk_i;
  logic   reset_i;
  logic   claim [2];
  logic   grant [2];
  logic   wsize_valid [2];
  size_t  wsize [2];
  logic   wvalid [2];
  addr_t  waddr [2];
  word_t  wdata [2];
  mask_t  wmask [2];
  logic   send [2];
  word_t  tdata;
  mask_t  tkeep;
  logic   tvalid;
  logic   tlast;
  logic   tuser;
  logic   tready;
  count_t send_count;

  logic [31:0] lfsr_r;
  int          ready_mode;     // 0 high, 1 random, 2 low
  int          errors;
  int          packets_sent;
  beat_t       exp_q [$];
  int          grant_order [$];
  beat_t       head_beat;

  eth_tx_top dut_i (
    .clk_i, .reset_i,
    .host0_claim_i (claim[0]), .host0_grant_o (grant[0]),
    .host0_wsize_valid_i (wsize_valid[0]), .host0_wsize_i (wsize[0]),
    .host0_wvalid_i (wvalid[0]), .host0_waddr_i (waddr[0]),
    .host0_wdata_i (wdata[0]), .host0_wmask_i (wmask[0]), .host0_send_i (send[0]),
    .host1_claim_i (claim[1]), .host1_grant_o (grant[1]),
    .host1_wsize_valid_i (wsize_valid[1]), .host1_wsize_i (wsize[1]),
    .host1_wvalid_i (wvalid[1]), .host1_waddr_i (waddr[1]),
    .host1_wdata_i (wdata[1]), .host1_wmask_i (wmask[1]), .host1_send_i (send[1]),
    .tx_axis_tdata_o (tdata), .tx_axis_tkeep_o (tkeep), .tx_axis_tvalid_o (tvalid),
    .tx_axis_tlast_o (tlast), .tx_axis_tuser_o (tuser), .tx_axis_tready_i (tready),
    .send_count_o (send_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
      lfsr_r = {lfsr_r[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic word_t byte_mask(input mask_t keep);
    word_t m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{keep[b]}};
    end
    return m;
  endfunction

  // expected beat idx of a packet of size bytes
  function automatic beat_t reference_beat(input word_t word, input int size, input int idx);
    beat_t r;
    int    nbeats;
    int    rem;
    nbeats = (size + 3) / 4;
    rem    = size % 4;
    r.keep = 4'hf;
    if (idx == nbeats - 1 && rem != 0) begin
      r.keep = mask_t'((1 << rem) - 1);   // low bytes only
    end
    r.last = (idx == nbeats - 1);
    r.data = word & byte_mask(r.keep);
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s actual 0x%0h expected 0x%0h", name, actual, expected);
      errors++;
    end
  endtask

  // entered and left 1 ns after a rising edge
  task automatic send_packet(input int host, input int size);
    int    nwords;
    word_t w;
    beat_t b;
    nwords      = (size + 3) / 4;
    claim[host] = 1'b1;
    do begin
      @(posedge clk_i);
      #1;
    end while (!grant[host]);
    grant_order.push_back(host);
    claim[host]       = 1'b0;
    wsize_valid[host] = 1'b1;
    wsize[host]       = size_t'(size);
    for (int i = 0; i < nwords; i++) begin
      w = random_bits(32);
      b = reference_beat(w, size, i);
      exp_q.push_back(b);
      wvalid[host] = 1'b1;
      waddr[host]  = addr_t'(i * 4);
      wdata[host]  = w;
      wmask[host]  = b.keep;   // unused tail bytes stay unwritten
      @(posedge clk_i);
      #1;
      wsize_valid[host] = 1'b0;
    end
    wvalid[host] = 1'b0;
    send[host]   = 1'b1;
    @(posedge clk_i);
    #1;
    send[host] = 1'b0;
    packets_sent++;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    #1;
  endtask

  task automatic finish_run();
    $display("run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  always @(posedge clk_i) begin
    #1;
    case (ready_mode)
      1:       tready = random_bits(1) == 32'd1;
      2:       tready = 1'b0;
      default: tready = 1'b1;
    endcase
  end

  // beats are taken where tvalid and tready are both settled
  always @(negedge clk_i) begin
    if (reset_i && tvalid && tready) begin
      if (exp_q.size() == 0) begin
        $display("beat accepted while no packet was expected");
        errors++;
      end else begin
        head_beat = exp_q.pop_front();
        check_value("tx_axis_tdata_o", tdata & byte_mask(head_beat.keep), head_beat.data);
        check_value("tx_axis_tkeep_o", 32'(tkeep), 32'(head_beat.keep));
        check_value("tx_axis_tlast_o", 32'(tlast), 32'(head_beat.last));
        check_value("tx_axis_tuser_o", 32'(tuser), 32'd0);
      end
    end
  end

  initial begin
    #(timeout_cycles_lp * 4);
    $display("timeout, the packet stream did not finish in time");
    errors++;
    finish_run();
  end

  initial begin
    lfsr_r       = 32'h78e0;
    ready_mode   = 0;
    errors       = 0;
    packets_sent = 0;
    reset_i      = 1'b0;
    tready       = 1'b1;
    for (int h = 0; h < 2; h++) begin
      claim[h]       = 1'b0;
      wsize_valid[h] = 1'b0;
      wsize[h]       = '0;
      wvalid[h]      = 1'b0;
      waddr[h]       = '0;
      wdata[h]       = '0;
      wmask[h]       = '0;
      send[h]        = 1'b0;
    end
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b1;
    check_value("host0_grant_o", 32'(grant[0]), 32'd0);
    check_value("host1_grant_o", 32'(grant[1]), 32'd0);
    check_value("tx_axis_tvalid_o", 32'(tvalid), 32'd0);
    check_value("send_count_o", 32'(send_count), 32'd0);

    // both hosts claim and host 0 gets the first grant after reset
    fork
      begin
        send_packet(0, 24);
        send_packet(0, 9);
      end
      begin
        send_packet(1, 16);
        send_packet(1, 30);
      end
    join
    wait_drain();
    for (int i = 0; i < grant_order.size(); i++) begin
      check_value("grant host", 32'(grant_order[i]), 32'(i % 2));
    end

    send_packet(0, 32);   // word multiple
    wait_drain();

    send_packet(0, 5);
    send_packet(0, 6);
    send_packet(0, 7);
    send_packet(0, 1);
    wait_drain();

    ready_mode = 1;
    fork
      repeat (3) send_packet(0, int'(random_bits(6)) + 1);
      repeat (3) send_packet(1, int'(random_bits(6)) + 1);
    join
    wait_drain();

    // both slots fill under stall so a third claim has to wait
    ready_mode = 2;
    repeat (2) @(posedge clk_i);
    #1;
    send_packet(0, 16);
    send_packet(0, 12);
    fork
      send_packet(1, 10);
      begin
        repeat (20) begin
          @(posedge clk_i);
          #1;
          check_value("host1_grant_o", 32'(grant[1]), 32'd0);
        end
        ready_mode = 0;
      end
    join
    wait_drain();

    check_value("send_count_o", 32'(send_count), 32'(packets_sent));
    finish_run();
  end

endmodule
